// File: design/bus_pkg.sv
package bus_pkg;

    // Default bus widths
    parameter int ADDR_W = 16;
    parameter int DATA_W = 8;

    // Address bit that picks the target, 0 for target 1 and 1 for target 2
    parameter int TARGET_SEL_BIT = 15;

    // Initiator that owns the bus
    typedef enum logic [1:0] {
        INIT_NONE = 2'b00,
        INIT_1    = 2'b01,
        INIT_2    = 2'b10
    } init_sel_t;

    // Target chosen by the decoder
    typedef enum logic [1:0] {
        TGT_NONE = 2'b00,
        TGT_1    = 2'b01,
        TGT_2    = 2'b10
    } target_sel_t;

endpackage

// File: design/init_port.sv
`timescale 1ns/1ps

module init_port
    import bus_pkg::*;
#(
    parameter int addr_w = ADDR_W,
    parameter int data_w = DATA_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  logic [addr_w-1:0] addr_out,
    input  logic [data_w-1:0] data_out,
    input  logic              rw,
    input  logic              ready,
    input  logic              bus_grant,
    input  logic              done,
    input  logic [data_w-1:0] rd_data,
    input  logic              rd_valid,
    output logic              grant,
    output logic [data_w-1:0] data_in,
    output logic              data_in_valid,
    output logic              ack,
    output logic              arb_req,
    output logic [addr_w-1:0] addr,
    output logic [data_w-1:0] wdata,
    output logic              wr
);

    logic pending;
    logic resp_pend;
    logic rd_flag;
    logic take;
    logic respond;

    // No new request while one is open or its ack is still on the port
    assign take    = req && !pending && !ack;
    assign respond = resp_pend && ready;

    always_ff @(posedge clk) begin
        if (take) begin
            addr  <= addr_out;
            wdata <= data_out;
            wr    <= rw;
        end
        if (done && rd_valid) begin
            data_in <= rd_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending       <= 1'b0;
            arb_req       <= 1'b0;
            resp_pend     <= 1'b0;
            rd_flag       <= 1'b0;
            grant         <= 1'b0;
            ack           <= 1'b0;
            data_in_valid <= 1'b0;
        end else begin
            grant         <= bus_grant && arb_req;
            ack           <= respond;
            data_in_valid <= respond && rd_flag;

            if (take) begin
                pending <= 1'b1;
                arb_req <= 1'b1;
            end

            // Bus is released here, the initiator may still stall the response
            if (done) begin
                arb_req   <= 1'b0;
                resp_pend <= 1'b1;
                rd_flag   <= rd_valid;
            end

            if (respond) begin
                resp_pend <= 1'b0;
                pending   <= 1'b0;
            end
        end
    end

endmodule

// File: design/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter
    import bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_1,
    input  logic      req_2,
    input  logic      done,
    output logic      grant_1,
    output logic      grant_2,
    output init_sel_t owner
);

    init_sel_t last_winner;
    logic      busy;
    logic      pick_1;
    logic      pick_2;

    assign busy = (owner != INIT_NONE);

    // On a tie the initiator not granted last goes first
    assign pick_1 = !busy && req_1 && (!req_2 || last_winner != INIT_1);
    assign pick_2 = !busy && req_2 && !pick_1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_1     <= 1'b0;
            grant_2     <= 1'b0;
            owner       <= INIT_NONE;
            last_winner <= INIT_NONE;
        end else begin
            grant_1 <= pick_1;
            grant_2 <= pick_2;

            if (pick_1) begin
                owner       <= INIT_1;
                last_winner <= INIT_1;
            end else if (pick_2) begin
                owner       <= INIT_2;
                last_winner <= INIT_2;
            end else if (done) begin
                owner <= INIT_NONE;
            end
        end
    end

endmodule

// File: design/addr_decoder.sv
`timescale 1ns/1ps

module addr_decoder
    import bus_pkg::*;
#(
    parameter int addr_w = ADDR_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [addr_w-1:0] addr,
    input  logic              start,
    input  logic              done,
    output target_sel_t       sel
);

    target_sel_t decoded;

    always_comb begin
        if (addr[TARGET_SEL_BIT]) begin
            decoded = TGT_2;
        end else begin
            decoded = TGT_1;
        end
    end

    // Select is held for the whole transaction and dropped after done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel <= TGT_NONE;
        end else if (done) begin
            sel <= TGT_NONE;
        end else if (start && sel == TGT_NONE) begin
            sel <= decoded;
        end
    end

endmodule

// File: design/target_port.sv
`timescale 1ns/1ps

module target_port
    import bus_pkg::*;
#(
    parameter int addr_w = ADDR_W,
    parameter int data_w = DATA_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              select,
    input  logic [addr_w-1:0] addr,
    input  logic [data_w-1:0] wdata,
    input  logic              wr,
    input  logic              ready,
    input  logic              ack,
    input  logic [data_w-1:0] data_out,
    input  logic              data_out_valid,
    output logic [addr_w-1:0] addr_in,
    output logic              addr_in_valid,
    output logic [data_w-1:0] data_in,
    output logic              data_in_valid,
    output logic              rw,
    output logic              done,
    output logic [data_w-1:0] rd_data,
    output logic              rd_valid
);

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        WAIT_ACK
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (state == IDLE && select && !done) begin
            addr_in <= addr;
            data_in <= wdata;
            rw      <= wr;
        end
        if (state == WAIT_ACK && ack) begin
            rd_data <= data_out;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE;
            addr_in_valid <= 1'b0;
            data_in_valid <= 1'b0;
            done          <= 1'b0;
            rd_valid      <= 1'b0;
        end else begin
            done     <= 1'b0;
            rd_valid <= 1'b0;
            case (state)
                IDLE: begin
                    // Select is still up in the done cycle, so skip that one
                    if (select && !done) begin
                        addr_in_valid <= 1'b1;
                        data_in_valid <= wr;
                        state         <= REQUEST;
                    end
                end
                REQUEST: begin
                    if (ready) begin
                        addr_in_valid <= 1'b0;
                        data_in_valid <= 1'b0;
                        state         <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (ack) begin
                        done     <= 1'b1;
                        rd_valid <= data_out_valid && !rw;
                        state    <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: design/bus_interconnect.sv
`timescale 1ns/1ps

module bus_interconnect
    import bus_pkg::*;
#(
    parameter int addr_w = ADDR_W,
    parameter int data_w = DATA_W
) (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              init1_req,
    input  logic [addr_w-1:0] init1_addr_out,
    input  logic [data_w-1:0] init1_data_out,
    input  logic              init1_rw,
    input  logic              init1_ready,
    output logic              init1_grant,
    output logic [data_w-1:0] init1_data_in,
    output logic              init1_data_in_valid,
    output logic              init1_ack,

    input  logic              init2_req,
    input  logic [addr_w-1:0] init2_addr_out,
    input  logic [data_w-1:0] init2_data_out,
    input  logic              init2_rw,
    input  logic              init2_ready,
    output logic              init2_grant,
    output logic [data_w-1:0] init2_data_in,
    output logic              init2_data_in_valid,
    output logic              init2_ack,

    input  logic              target1_ready,
    input  logic              target1_ack,
    input  logic [data_w-1:0] target1_data_out,
    input  logic              target1_data_out_valid,
    output logic [addr_w-1:0] target1_addr_in,
    output logic              target1_addr_in_valid,
    output logic [data_w-1:0] target1_data_in,
    output logic              target1_data_in_valid,
    output logic              target1_rw,

    input  logic              target2_ready,
    input  logic              target2_ack,
    input  logic [data_w-1:0] target2_data_out,
    input  logic              target2_data_out_valid,
    output logic [addr_w-1:0] target2_addr_in,
    output logic              target2_addr_in_valid,
    output logic [data_w-1:0] target2_data_in,
    output logic              target2_data_in_valid,
    output logic              target2_rw
);

    logic              i1_arb_req;
    logic [addr_w-1:0] i1_addr;
    logic [data_w-1:0] i1_wdata;
    logic              i1_wr;
    logic              i1_done;
    logic              i1_rd_valid;

    logic              i2_arb_req;
    logic [addr_w-1:0] i2_addr;
    logic [data_w-1:0] i2_wdata;
    logic              i2_wr;
    logic              i2_done;
    logic              i2_rd_valid;

    logic              arb_grant_1;
    logic              arb_grant_2;
    init_sel_t         owner;
    target_sel_t       sel;

    logic [addr_w-1:0] fwd_addr;
    logic [data_w-1:0] fwd_wdata;
    logic              fwd_wr;
    logic              fwd_start;

    logic              t1_done;
    logic [data_w-1:0] t1_rd_data;
    logic              t1_rd_valid;
    logic              t2_done;
    logic [data_w-1:0] t2_rd_data;
    logic              t2_rd_valid;

    logic              ret_done;
    logic [data_w-1:0] ret_rd_data;
    logic              ret_rd_valid;

    init_port #(
        .addr_w(addr_w),
        .data_w(data_w)
    ) u_init_port_1 (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (init1_req),
        .addr_out     (init1_addr_out),
        .data_out     (init1_data_out),
        .rw           (init1_rw),
        .ready        (init1_ready),
        .bus_grant    (arb_grant_1),
        .done         (i1_done),
        .rd_data      (ret_rd_data),
        .rd_valid     (i1_rd_valid),
        .grant        (init1_grant),
        .data_in      (init1_data_in),
        .data_in_valid(init1_data_in_valid),
        .ack          (init1_ack),
        .arb_req      (i1_arb_req),
        .addr         (i1_addr),
        .wdata        (i1_wdata),
        .wr           (i1_wr)
    );

    init_port #(
        .addr_w(addr_w),
        .data_w(data_w)
    ) u_init_port_2 (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (init2_req),
        .addr_out     (init2_addr_out),
        .data_out     (init2_data_out),
        .rw           (init2_rw),
        .ready        (init2_ready),
        .bus_grant    (arb_grant_2),
        .done         (i2_done),
        .rd_data      (ret_rd_data),
        .rd_valid     (i2_rd_valid),
        .grant        (init2_grant),
        .data_in      (init2_data_in),
        .data_in_valid(init2_data_in_valid),
        .ack          (init2_ack),
        .arb_req      (i2_arb_req),
        .addr         (i2_addr),
        .wdata        (i2_wdata),
        .wr           (i2_wr)
    );

    bus_arbiter u_bus_arbiter (
        .clk    (clk),
        .rst_n  (rst_n),
        .req_1  (i1_arb_req),
        .req_2  (i2_arb_req),
        .done   (ret_done),
        .grant_1(arb_grant_1),
        .grant_2(arb_grant_2),
        .owner  (owner)
    );

    // Forward path follows the bus owner, owner is set in the grant cycle
    always_comb begin
        fwd_addr  = '0;
        fwd_wdata = '0;
        fwd_wr    = 1'b0;
        fwd_start = 1'b0;
        case (owner)
            INIT_1: begin
                fwd_addr  = i1_addr;
                fwd_wdata = i1_wdata;
                fwd_wr    = i1_wr;
                fwd_start = arb_grant_1;
            end
            INIT_2: begin
                fwd_addr  = i2_addr;
                fwd_wdata = i2_wdata;
                fwd_wr    = i2_wr;
                fwd_start = arb_grant_2;
            end
            default: ;
        endcase
    end

    addr_decoder #(
        .addr_w(addr_w)
    ) u_addr_decoder (
        .clk  (clk),
        .rst_n(rst_n),
        .addr (fwd_addr),
        .start(fwd_start),
        .done (ret_done),
        .sel  (sel)
    );

    target_port #(
        .addr_w(addr_w),
        .data_w(data_w)
    ) u_target_port_1 (
        .clk           (clk),
        .rst_n         (rst_n),
        .select        (sel == TGT_1),
        .addr          (fwd_addr),
        .wdata         (fwd_wdata),
        .wr            (fwd_wr),
        .ready         (target1_ready),
        .ack           (target1_ack),
        .data_out      (target1_data_out),
        .data_out_valid(target1_data_out_valid),
        .addr_in       (target1_addr_in),
        .addr_in_valid (target1_addr_in_valid),
        .data_in       (target1_data_in),
        .data_in_valid (target1_data_in_valid),
        .rw            (target1_rw),
        .done          (t1_done),
        .rd_data       (t1_rd_data),
        .rd_valid      (t1_rd_valid)
    );

    target_port #(
        .addr_w(addr_w),
        .data_w(data_w)
    ) u_target_port_2 (
        .clk           (clk),
        .rst_n         (rst_n),
        .select        (sel == TGT_2),
        .addr          (fwd_addr),
        .wdata         (fwd_wdata),
        .wr            (fwd_wr),
        .ready         (target2_ready),
        .ack           (target2_ack),
        .data_out      (target2_data_out),
        .data_out_valid(target2_data_out_valid),
        .addr_in       (target2_addr_in),
        .addr_in_valid (target2_addr_in_valid),
        .data_in       (target2_data_in),
        .data_in_valid (target2_data_in_valid),
        .rw            (target2_rw),
        .done          (t2_done),
        .rd_data       (t2_rd_data),
        .rd_valid      (t2_rd_valid)
    );

    // Return path from the selected target
    always_comb begin
        ret_done     = 1'b0;
        ret_rd_data  = t1_rd_data;
        ret_rd_valid = 1'b0;
        case (sel)
            TGT_1: begin
                ret_done     = t1_done;
                ret_rd_valid = t1_rd_valid;
            end
            TGT_2: begin
                ret_done     = t2_done;
                ret_rd_data  = t2_rd_data;
                ret_rd_valid = t2_rd_valid;
            end
            default: ;
        endcase
    end

    // Steered back to the owning initiator
    always_comb begin
        i1_done     = 1'b0;
        i1_rd_valid = 1'b0;
        i2_done     = 1'b0;
        i2_rd_valid = 1'b0;
        case (owner)
            INIT_1: begin
                i1_done     = ret_done;
                i1_rd_valid = ret_rd_valid;
            end
            INIT_2: begin
                i2_done     = ret_done;
                i2_rd_valid = ret_rd_valid;
            end
            default: ;
        endcase
    end

endmodule

// File: tests/tb_bus.sv
`timescale 1ns/1ps

module tb_bus
    import bus_pkg::*;
();

    localparam int NUM_TXN = 200;
    localparam int TIMEOUT = 1000;
    localparam int unsigned SEED = 32'h09dbbdd7;

    logic clk;
    logic rst_n;

    // Index 0 is initiator 1 or target 1
    logic              req_q       [2];
    logic [ADDR_W-1:0] addr_q      [2];
    logic [DATA_W-1:0] data_q      [2];
    logic              rw_q        [2];
    logic              iready      [2];
    logic              grant_w     [2];
    logic [DATA_W-1:0] rdata_w     [2];
    logic              rvalid_w    [2];
    logic              ack_w       [2];

    logic              t_ready     [2];
    logic              t_ack       [2];
    logic [DATA_W-1:0] t_dout      [2];
    logic              t_dvalid    [2];
    logic [ADDR_W-1:0] t_addr      [2];
    logic              t_avalid    [2];
    logic [DATA_W-1:0] t_din       [2];
    logic              t_din_valid [2];
    logic              t_rw        [2];

    logic [DATA_W-1:0] ref_mem [0:(1<<ADDR_W)-1];
    logic [DATA_W-1:0] tgt_mem [2][0:(1<<ADDR_W)-1];

    logic [ADDR_W-1:0] exp_addr    [2];
    logic [DATA_W-1:0] exp_data    [2];
    logic              exp_rw      [2];
    logic              reached     [2];
    logic              granted     [2];
    int                req_since   [2];
    int                grant_count [2];
    int                ack_count   [2];
    int                owner_tb;
    int                last_grant;
    logic              timed_out;
    int                mismatch_count;
    int                other_count;

    bus_interconnect #(
        .addr_w(ADDR_W),
        .data_w(DATA_W)
    ) DUT (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .init1_req             (req_q[0]),
        .init1_addr_out        (addr_q[0]),
        .init1_data_out        (data_q[0]),
        .init1_rw              (rw_q[0]),
        .init1_ready           (iready[0]),
        .init1_grant           (grant_w[0]),
        .init1_data_in         (rdata_w[0]),
        .init1_data_in_valid   (rvalid_w[0]),
        .init1_ack             (ack_w[0]),
        .init2_req             (req_q[1]),
        .init2_addr_out        (addr_q[1]),
        .init2_data_out        (data_q[1]),
        .init2_rw              (rw_q[1]),
        .init2_ready           (iready[1]),
        .init2_grant           (grant_w[1]),
        .init2_data_in         (rdata_w[1]),
        .init2_data_in_valid   (rvalid_w[1]),
        .init2_ack             (ack_w[1]),
        .target1_ready         (t_ready[0]),
        .target1_ack           (t_ack[0]),
        .target1_data_out      (t_dout[0]),
        .target1_data_out_valid(t_dvalid[0]),
        .target1_addr_in       (t_addr[0]),
        .target1_addr_in_valid (t_avalid[0]),
        .target1_data_in       (t_din[0]),
        .target1_data_in_valid (t_din_valid[0]),
        .target1_rw            (t_rw[0]),
        .target2_ready         (t_ready[1]),
        .target2_ack           (t_ack[1]),
        .target2_data_out      (t_dout[1]),
        .target2_data_out_valid(t_dvalid[1]),
        .target2_addr_in       (t_addr[1]),
        .target2_addr_in_valid (t_avalid[1]),
        .target2_data_in       (t_din[1]),
        .target2_data_in_valid (t_din_valid[1]),
        .target2_rw            (t_rw[1])
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        mismatch_count++;
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic report_failure(input string what);
        other_count++;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic check_low(input string name, input logic value);
        assert (!value) else report_mismatch(name, 32'(value), 32'd0);
    endtask

    task automatic check_request(input int t, input logic [ADDR_W-1:0] a, input logic w);
        int o;
        string tn;
        o = owner_tb;
        tn = $sformatf("target%0d", t + 1);
        assert (o >= 0) else report_failure({tn, " accepted a request with no grant held"});
        if (o >= 0) begin
            assert (!reached[o]) else report_failure(
                $sformatf("init%0d request reached a target twice", o + 1));
            reached[o] = 1'b1;
            assert (a[TARGET_SEL_BIT] == 1'(t)) else report_failure(
                $sformatf("request for address %h reached %s", a, tn));
            assert (a == exp_addr[o]) else report_mismatch({tn, "_addr_in"}, 32'(a),
                32'(exp_addr[o]));
            assert (w == exp_rw[o]) else report_mismatch({tn, "_rw"}, 32'(w), 32'(exp_rw[o]));
            assert (t_din_valid[t] == exp_rw[o]) else report_mismatch({tn, "_data_in_valid"},
                32'(t_din_valid[t]), 32'(exp_rw[o]));
            if (exp_rw[o]) begin
                assert (t_din[t] == exp_data[o]) else report_mismatch({tn, "_data_in"},
                    32'(t_din[t]), 32'(exp_data[o]));
            end
        end
    endtask

    // Responder with random ready stalls and ack delays
    task automatic serve_target(input int t);
        logic              busy;
        int                delay;
        logic [ADDR_W-1:0] a;
        logic              w;
        busy = 1'b0;
        delay = 0;
        a = '0;
        w = 1'b0;
        forever begin
            @(posedge clk);
            t_ack[t] <= 1'b0;
            t_dvalid[t] <= 1'b0;
            t_ready[t] <= ($urandom_range(0, 2) != 0);
            if (!rst_n) begin
                busy = 1'b0;
            end else if (busy) begin
                assert (!t_avalid[t]) else report_failure(
                    $sformatf("target%0d saw a new request before its ack", t + 1));
                if (delay == 0) begin
                    t_ack[t] <= 1'b1;
                    if (!w) begin
                        t_dout[t] <= tgt_mem[t][a];
                        t_dvalid[t] <= 1'b1;
                    end
                    busy = 1'b0;
                end else begin
                    delay--;
                end
            end else if (t_avalid[t] && t_ready[t]) begin
                a = t_addr[t];
                w = t_rw[t];
                check_request(t, a, w);
                if (w) begin
                    tgt_mem[t][a] = t_din[t];
                end
                busy = 1'b1;
                delay = $urandom_range(0, 6);
            end
        end
    endtask

    // Tracks bus ownership, grant order and pulse counts
    task automatic watch_bus();
        int   cycle;
        int   winner;
        logic rival_req;
        cycle = 0;
        forever begin
            @(posedge clk);
            cycle++;
            if (rst_n) begin
                // Port takes a new request on the first edge it sees it
                for (int n = 0; n < 2; n++) begin
                    if (req_q[n] && !granted[n] && req_since[n] < 0) begin
                        req_since[n] = cycle;
                    end
                end
                for (int n = 0; n < 2; n++) begin
                    if (ack_w[n]) begin
                        assert (granted[n]) else report_failure(
                            $sformatf("init%0d got an ack without a grant", n + 1));
                        granted[n] = 1'b0;
                        ack_count[n]++;
                        if (owner_tb == n) begin
                            owner_tb = -1;
                        end
                    end
                end
                for (int n = 0; n < 2; n++) begin
                    if (grant_w[n]) begin
                        assert (owner_tb < 0) else report_failure(
                            $sformatf("init%0d granted while the bus was still held", n + 1));
                        // Arbiter picked two edges back, rival arb_req rises one after take
                        rival_req = (req_since[1 - n] >= 0) && (req_since[1 - n] <= cycle - 3);
                        winner = (last_grant == 0) ? 1 : 0;
                        assert (!rival_req || n == winner) else report_failure(
                            $sformatf("init%0d granted while init%0d was due", n + 1, 2 - n));
                        req_since[n] = -1;
                        last_grant = n;
                        granted[n] = 1'b1;
                        owner_tb = n;
                        grant_count[n]++;
                    end
                end
            end
        end
    endtask

    task automatic run_initiator(input int n);
        int                gap;
        int                waited;
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d;
        logic              w;
        for (int i = 0; i < NUM_TXN && !timed_out; i++) begin
            // Alternate between back-to-back phases and sparse traffic
            gap = ((i / 25) % 2 == 0) ? 1 : int'($urandom_range(1, 12));
            repeat (gap) @(posedge clk);
            a = '0;
            a[TARGET_SEL_BIT] = 1'($urandom_range(0, 1));
            a[3:0] = 4'($urandom_range(0, 15));
            d = DATA_W'($urandom);
            w = 1'($urandom_range(0, 1));
            exp_addr[n] = a;
            exp_data[n] = d;
            exp_rw[n] = w;
            reached[n] = 1'b0;
            req_q[n] <= 1'b1;
            addr_q[n] <= a;
            data_q[n] <= d;
            rw_q[n] <= w;
            waited = 0;
            @(posedge clk);
            while (!grant_w[n] && waited < TIMEOUT) begin
                @(posedge clk);
                waited++;
            end
            if (!grant_w[n]) begin
                report_failure($sformatf("init%0d timed out waiting for a grant", n + 1));
                timed_out = 1'b1;
            end else begin
                waited = 0;
                @(posedge clk);
                while (!ack_w[n] && waited < TIMEOUT) begin
                    @(posedge clk);
                    waited++;
                end
                if (!ack_w[n]) begin
                    report_failure($sformatf("init%0d timed out waiting for an ack", n + 1));
                    timed_out = 1'b1;
                end else begin
                    assert (reached[n]) else report_failure(
                        $sformatf("init%0d got an ack for a request no target saw", n + 1));
                    assert (rvalid_w[n] == !w) else report_mismatch(
                        $sformatf("init%0d_data_in_valid", n + 1), 32'(rvalid_w[n]), 32'(!w));
                    if (w) begin
                        ref_mem[a] = d;
                    end else begin
                        assert (rdata_w[n] == ref_mem[a]) else report_mismatch(
                            $sformatf("init%0d_data_in", n + 1), 32'(rdata_w[n]),
                            32'(ref_mem[a]));
                    end
                    req_q[n] <= 1'b0;
                end
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n = 1'b0;
        owner_tb = -1;
        last_grant = -1;
        timed_out = 1'b0;
        mismatch_count = 0;
        other_count = 0;
        for (int i = 0; i < 2; i++) begin
            req_q[i] = 1'b0;
            addr_q[i] = '0;
            data_q[i] = '0;
            rw_q[i] = 1'b0;
            iready[i] = 1'b1;
            t_ready[i] = 1'b0;
            t_ack[i] = 1'b0;
            t_dout[i] = '0;
            t_dvalid[i] = 1'b0;
            reached[i] = 1'b0;
            granted[i] = 1'b0;
            req_since[i] = -1;
            grant_count[i] = 0;
            ack_count[i] = 0;
        end
        for (int i = 0; i < (1 << ADDR_W); i++) begin
            ref_mem[i] = '0;
            tgt_mem[0][i] = '0;
            tgt_mem[1][i] = '0;
        end
        fork
            serve_target(0);
            serve_target(1);
            watch_bus();
        join_none

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        for (int n = 0; n < 2; n++) begin
            check_low($sformatf("init%0d_grant", n + 1), grant_w[n]);
            check_low($sformatf("init%0d_ack", n + 1), ack_w[n]);
            check_low($sformatf("init%0d_data_in_valid", n + 1), rvalid_w[n]);
            check_low($sformatf("target%0d_addr_in_valid", n + 1), t_avalid[n]);
            check_low($sformatf("target%0d_data_in_valid", n + 1), t_din_valid[n]);
        end

        fork
            run_initiator(0);
            run_initiator(1);
        join
        // Let any stray pulse show up in the counts
        repeat (20) @(posedge clk);
        for (int n = 0; n < 2; n++) begin
            assert (grant_count[n] == NUM_TXN) else report_mismatch(
                $sformatf("init%0d grant count", n + 1), grant_count[n], NUM_TXN);
            assert (ack_count[n] == NUM_TXN) else report_mismatch(
                $sformatf("init%0d ack count", n + 1), ack_count[n], NUM_TXN);
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
design/bus_pkg.sv
design/init_port.sv
design/bus_arbiter.sv
design/addr_decoder.sv
design/target_port.sv
design/bus_interconnect.sv
tests/tb_bus.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f list.f --top-module tb_bus -o tb_bus_sim

./obj_dir/tb_bus_sim > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
